// File: tb.f
src/gate_pkg.sv
src/event_fifo.sv
src/gate_controller.sv
src/tx_modulator.sv
src/sequencer_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --timescale 1ns/1ps --top-module tb_top -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// File: verif/tb_top.sv
module tb_top import gate_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int fifo_depth = 16;
  localparam int clk_period = 20;
  localparam int n_rows     = 7;

  typedef struct {
    int         n_tx;
    int         tx_dur;
    logic [1:0] tx_bits;  // {gate, sync}.
    int         n_rx;
    int         rx_dur;
    logic       rx_en;
    int         exp_gate;
    int         exp_sync;
    int         exp_out;
  } test_row_t;

  // ====================================================================
  // stimulus table
  // ====================================================================
  test_row_t rows [n_rows] = '{
    '{ 0,  0, 2'b00, 0, 0, 1'b0,   0,   0,  0},  // nothing queued.
    '{ 1,  5, 2'b11, 0, 0, 1'b0,   6,   6,  0},
    '{ 3,  4, 2'b10, 0, 0, 1'b0,  15,   0,  0},  // back to back, carrier runs free.
    '{ 0,  0, 2'b00, 3, 6, 1'b1,   0,   0, 21},
    '{ 0,  0, 2'b00, 2, 5, 1'b0,   0,   0,  0},  // closed windows.
    '{ 2,  3, 2'b01, 2, 4, 1'b1,   0,   8, 10},
    // first event keeps the controller busy while depth+2 more are written.
    '{19, 30, 2'b11, 0, 0, 1'b0, 527, 527,  0}
  };

  logic                aclk;
  logic                aresetn;
  tx_event_t           tx_evt;
  logic                tx_evt_wr;
  logic                tx_full;
  rx_event_t           rx_evt;
  logic                rx_evt_wr;
  logic                rx_full;
  logic [sample_w-1:0] sample_data;
  logic                sample_valid;
  logic [sample_w-1:0] out_data;
  logic                out_valid;
  logic                sync;
  logic                gate;
  logic [level_w-1:0]  tx_amp;
  logic [phase_w-1:0]  carrier_phase;
  logic [phase_w-1:0]  rx_phase;
  logic                test_done;
  logic                run_done;
  logic                idle;
  int                  test_num;
  int                  exp_gate;
  int                  exp_sync;
  int                  exp_out;
  int                  errors;
  logic [31:0]         rand_state = 32'd24552;

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  function automatic tx_event_t tx_event_for(int r, int k);
    tx_event_t   e;
    logic [31:0] x;
    x          = xorshift32();
    e          = '0;
    e.duration = dur_w'(rows[r].tx_dur);
    e.sync_bit = rows[r].tx_bits[0];
    e.gate_bit = rows[r].tx_bits[1];
    e.level    = level_w'(256 * (r + 1) + k + 1); // distinct level per event.
    e.tx_phase = x[phase_w-1:0];
    e.rx_phase = x[31:2];
    return e;
  endfunction

  function automatic rx_event_t rx_event_for(int r);
    rx_event_t e;
    e           = '0;
    e.duration  = dur_w'(rows[r].rx_dur);
    e.rx_enable = rows[r].rx_en;
    return e;
  endfunction

  // new random sample each cycle, valid about half the time.
  task automatic advance_cycle();
    logic [31:0] x;
    @(posedge aclk);
    #2;
    x            = xorshift32();
    sample_valid = x[0];
    sample_data  = {x, ~x, {x[15:0], x[31:16]}, x ^ 32'h5a5a_a5a5};
  endtask

  initial
  begin
    aclk = 1'b0;
    forever #(clk_period / 2) aclk = ~aclk;
  end

  // watchdog sized from the table.
  initial
  begin
    int budget;
    budget = 40;
    for (int r = 0; r < n_rows; r++)
      budget = budget + rows[r].n_tx * (rows[r].tx_dur + 1) + rows[r].n_tx + rows[r].n_rx +
               4 * rows[r].n_rx * (rows[r].rx_dur + 1) + 20;
    #(budget * clk_period);
    $display("watchdog: sequencer still busy after %0d cycles", budget);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    aresetn      = 1'b0;
    tx_evt       = '0;
    tx_evt_wr    = 1'b0;
    rx_evt       = '0;
    rx_evt_wr    = 1'b0;
    sample_data  = '0;
    sample_valid = 1'b0;
    test_done    = 1'b0;
    run_done     = 1'b0;
    test_num     = 0;
    exp_gate     = 0;
    exp_sync     = 0;
    exp_out      = 0;
    repeat (3) @(posedge aclk);
    #2;
    aresetn = 1'b1;

    for (int r = 0; r < n_rows; r++)
    begin
      for (int k = 0; k < rows[r].n_tx || k < rows[r].n_rx; k++)
      begin
        advance_cycle();
        tx_evt_wr = (k < rows[r].n_tx);
        tx_evt    = tx_event_for(r, k);
        rx_evt_wr = (k < rows[r].n_rx);
        rx_evt    = rx_event_for(r);
      end
      advance_cycle();
      tx_evt_wr = 1'b0;
      rx_evt_wr = 1'b0;
      do
        advance_cycle();
      while (!idle);
      repeat (4) advance_cycle();  // let the last outputs drain.
      test_num  = r;
      exp_gate  = rows[r].exp_gate;
      exp_sync  = rows[r].exp_sync;
      exp_out   = rows[r].exp_out;
      test_done = 1'b1;
      advance_cycle();
      test_done = 1'b0;
    end

    run_done = 1'b1;
    advance_cycle();
    run_done = 1'b0;
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  sequencer_top #(.fifo_depth(fifo_depth)) dut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .tx_evt        (tx_evt),
    .tx_evt_wr     (tx_evt_wr),
    .tx_full       (tx_full),
    .rx_evt        (rx_evt),
    .rx_evt_wr     (rx_evt_wr),
    .rx_full       (rx_full),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .sync          (sync),
    .gate          (gate),
    .tx_amp        (tx_amp),
    .carrier_phase (carrier_phase),
    .rx_phase      (rx_phase)
  );

  tb_checker #(.fifo_depth(fifo_depth)) u_chk (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .tx_evt        (tx_evt),
    .tx_evt_wr     (tx_evt_wr),
    .tx_full       (tx_full),
    .rx_evt        (rx_evt),
    .rx_evt_wr     (rx_evt_wr),
    .rx_full       (rx_full),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .sync          (sync),
    .gate          (gate),
    .tx_amp        (tx_amp),
    .carrier_phase (carrier_phase),
    .rx_phase      (rx_phase),
    .test_done     (test_done),
    .test_num      (test_num),
    .exp_gate      (exp_gate),
    .exp_sync      (exp_sync),
    .exp_out       (exp_out),
    .run_done      (run_done),
    .idle          (idle),
    .errors        (errors)
  );

endmodule

// File: verif/tb_checker.sv
module tb_checker import gate_pkg::*; #(
  parameter int fifo_depth = 16
)
(
  input  logic                aclk,
  input  logic                aresetn,
  input  tx_event_t           tx_evt,
  input  logic                tx_evt_wr,
  input  logic                tx_full,
  input  rx_event_t           rx_evt,
  input  logic                rx_evt_wr,
  input  logic                rx_full,
  input  logic [sample_w-1:0] sample_data,
  input  logic                sample_valid,
  input  logic [sample_w-1:0] out_data,
  input  logic                out_valid,
  input  logic                sync,
  input  logic                gate,
  input  logic [level_w-1:0]  tx_amp,
  input  logic [phase_w-1:0]  carrier_phase,
  input  logic [phase_w-1:0]  rx_phase,
  input  logic                test_done,
  input  int                  test_num,
  input  int                  exp_gate,
  input  int                  exp_sync,
  input  int                  exp_out,
  input  logic                run_done,
  output logic                idle,
  output int                  errors
);

  timeunit 1ns;
  timeprecision 100ps;

  tx_event_t           tx_q [$]; // reference copies of both queues.
  rx_event_t           rx_q [$];
  tx_event_t           cur_tx;
  logic                cur_en;
  logic [dur_w-1:0]    tx_cnt;
  logic [dur_w-1:0]    rx_cnt;
  logic                live;
  logic                e_sync;
  logic                e_gate;
  logic                e_outv;
  logic [level_w-1:0]  e_amp;
  logic [phase_w-1:0]  e_phase;
  logic [sample_w-1:0] e_data;
  int                  n_gate;
  int                  n_sync;
  int                  n_out;
  int                  test_errs;
  int                  passed;
  int                  failed;

  task automatic compare(string what, logic [sample_w-1:0] got, logic [sample_w-1:0] expd);
    if (got !== expd)
    begin
      errors    = errors + 1;
      test_errs = test_errs + 1;
      $display("CHECK FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, expd);
    end
  endtask

  always @(posedge aclk)
  begin
    logic      win;
    rx_event_t rx_head;
    int        tx_fill;
    int        rx_fill;
    if (!aresetn)
    begin
      tx_q.delete();
      rx_q.delete();
      cur_tx    = '0;
      cur_en    = 1'b0;
      tx_cnt    = '0;
      rx_cnt    = '0;
      live      = 1'b0;
      e_sync    = 1'b0;
      e_gate    = 1'b0;
      e_outv    = 1'b0;
      e_amp     = '0;
      e_phase   = '0;
      e_data    = '0;
      n_gate    = 0;
      n_sync    = 0;
      n_out     = 0;
      test_errs = 0;
      passed    = 0;
      failed    = 0;
      errors    = 0;
      idle     <= 1'b1;
    end
    else
    begin
      tx_fill = tx_q.size();
      rx_fill = rx_q.size();

      // ================================================================
      // outputs now show what the previous edge produced
      // ================================================================
      compare("sync", sample_w'(sync), sample_w'(e_sync));
      compare("gate", sample_w'(gate), sample_w'(e_gate));
      compare("tx_amp", sample_w'(tx_amp), sample_w'(e_amp));
      compare("carrier_phase", sample_w'(carrier_phase), sample_w'(e_phase));
      compare("rx_phase", sample_w'(rx_phase),
              sample_w'(cur_tx[tx_rx_phase_lsb +: phase_w]));
      compare("out_valid", sample_w'(out_valid), sample_w'(e_outv));
      if (e_outv)
        compare("out_data", out_data, e_data);
      compare("tx_full", sample_w'(tx_full), sample_w'(tx_fill == fifo_depth));
      compare("rx_full", sample_w'(rx_full), sample_w'(rx_fill == fifo_depth));
      n_gate = n_gate + int'(gate);
      n_sync = n_sync + int'(sync);
      n_out  = n_out + int'(out_valid);

      // ================================================================
      // reference model runs one edge ahead
      // ================================================================
      e_amp   = e_gate ? cur_tx[tx_level_lsb +: level_w] : '0; // modulator lags by one cycle.
      e_phase = e_sync ? '0 : e_phase + cur_tx[tx_phase_lsb +: phase_w];

      if (tx_cnt != '0)
        tx_cnt = tx_cnt - dur_w'(1);                     // bits held for duration+1 cycles.
      else if (live && tx_fill > 0)
      begin
        cur_tx = tx_q.pop_front();
        tx_cnt = cur_tx[dur_w-1:0];
        e_sync = cur_tx[tx_sync_pos];
        e_gate = cur_tx[tx_gate_pos];
      end
      else
      begin
        e_sync = 1'b0;
        e_gate = 1'b0;
      end

      // receive window counts samples rather than clocks.
      win = 1'b0;
      if (sample_valid && rx_cnt != '0)
      begin
        rx_cnt = rx_cnt - dur_w'(1);
        win    = cur_en;
      end
      else if (sample_valid && live && rx_fill > 0)
      begin
        rx_head = rx_q.pop_front();
        rx_cnt  = rx_head[dur_w-1:0];
        cur_en  = rx_head[rx_enable_pos];
        win     = rx_head[rx_enable_pos];
      end
      e_outv = win;
      e_data = sample_data;

      if (tx_evt_wr && tx_fill < fifo_depth)
        tx_q.push_back(tx_evt);                          // a write into a full queue is lost.
      if (rx_evt_wr && rx_fill < fifo_depth)
        rx_q.push_back(rx_evt);
      live  = 1'b1;
      idle <= (tx_q.size() == 0) && (rx_q.size() == 0) && (tx_cnt == '0) &&
              (rx_cnt == '0) && !e_sync && !e_gate;

      if (test_done)
      begin
        compare("gate cycles", sample_w'(n_gate), sample_w'(exp_gate));
        compare("sync cycles", sample_w'(n_sync), sample_w'(exp_sync));
        compare("out_valid pulses", sample_w'(n_out), sample_w'(exp_out));
        if (test_errs == 0)
        begin
          passed = passed + 1;
          $display("test %0d passed: gate %0d, sync %0d, out %0d", test_num, n_gate, n_sync,
                   n_out);
        end
        else
        begin
          failed = failed + 1;
          $display("test %0d failed with %0d errors", test_num, test_errs);
        end
        n_gate    = 0;
        n_sync    = 0;
        n_out     = 0;
        test_errs = 0;
      end
      if (run_done)
        $display("totals: %0d tests passed, %0d failed, %0d check errors", passed, failed,
                 errors);
    end
  end

endmodule

// File: src/sequencer_top.sv
module sequencer_top import gate_pkg::*; #(
  parameter int fifo_depth = 16
)
(
  input  logic                aclk,
  input  logic                aresetn,

  input  tx_event_t           tx_evt,
  input  logic                tx_evt_wr,
  output logic                tx_full,

  input  rx_event_t           rx_evt,
  input  logic                rx_evt_wr,
  output logic                rx_full,

  input  logic [sample_w-1:0] sample_data,
  input  logic                sample_valid,

  output logic [sample_w-1:0] out_data,
  output logic                out_valid,

  output logic                sync,
  output logic                gate,
  output logic [level_w-1:0]  tx_amp,
  output logic [phase_w-1:0]  carrier_phase,
  output logic [phase_w-1:0]  rx_phase
);

  tx_event_t          tx_evt_data;
  logic               tx_evt_valid;
  logic               tx_evt_ready;
  rx_event_t          rx_evt_data;
  logic               rx_evt_valid;
  logic               rx_evt_ready;
  logic [level_w-1:0] level;
  logic [phase_w-1:0] tx_phase;

  // ====================================================================
  // event queues
  // ====================================================================
  event_fifo #(.payload_t(tx_event_t), .fifo_depth(fifo_depth)) u_tx_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_data  (tx_evt),
    .wr_en    (tx_evt_wr),
    .full     (tx_full),
    .rd_data  (tx_evt_data),
    .rd_valid (tx_evt_valid),
    .rd_ready (tx_evt_ready)
  );

  event_fifo #(.payload_t(rx_event_t), .fifo_depth(fifo_depth)) u_rx_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_data  (rx_evt),
    .wr_en    (rx_evt_wr),
    .full     (rx_full),
    .rd_data  (rx_evt_data),
    .rd_valid (rx_evt_valid),
    .rd_ready (rx_evt_ready)
  );

  gate_controller u_ctrl (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .tx_evt_data  (tx_evt_data),
    .tx_evt_valid (tx_evt_valid),
    .tx_evt_ready (tx_evt_ready),
    .rx_evt_data  (rx_evt_data),
    .rx_evt_valid (rx_evt_valid),
    .rx_evt_ready (rx_evt_ready),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .tx_phase     (tx_phase),
    .rx_phase     (rx_phase),
    .level        (level),
    .sync         (sync),
    .gate         (gate)
  );

  tx_modulator u_mod (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .sync          (sync),
    .gate          (gate),
    .level         (level),
    .tx_phase      (tx_phase),
    .tx_amp        (tx_amp),
    .carrier_phase (carrier_phase)
  );

endmodule

// File: src/tx_modulator.sv
module tx_modulator import gate_pkg::*;
(
  input  logic               aclk,
  input  logic               aresetn,

  input  logic               sync,
  input  logic               gate,
  input  logic [level_w-1:0] level,
  input  logic [phase_w-1:0] tx_phase,

  output logic [level_w-1:0] tx_amp,
  output logic [phase_w-1:0] carrier_phase
);

  logic [phase_w-1:0] phase_acc;
  logic [level_w-1:0] amp_q;

  // ====================================================================
  // carrier phase accumulator
  // ====================================================================
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      phase_acc <= '0;
    else if (sync)
      phase_acc <= '0;                   // restart the carrier.
    else
      phase_acc <= phase_acc + tx_phase; // wraps mod 2^30.
  end

  // ====================================================================
  // gated amplitude
  // ====================================================================
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      amp_q <= '0;
    else if (gate)
      amp_q <= level;
    else
      amp_q <= '0;
  end

  assign tx_amp        = amp_q;
  assign carrier_phase = phase_acc;

endmodule

// File: src/gate_controller.sv
module gate_controller import gate_pkg::*;
(
  input  logic                aclk,
  input  logic                aresetn,

  input  tx_event_t           tx_evt_data,
  input  logic                tx_evt_valid,
  output logic                tx_evt_ready,

  input  rx_event_t           rx_evt_data,
  input  logic                rx_evt_valid,
  output logic                rx_evt_ready,

  input  logic [sample_w-1:0] sample_data,
  input  logic                sample_valid,

  output logic [sample_w-1:0] out_data,
  output logic                out_valid,

  output logic [phase_w-1:0]  tx_phase,
  output logic [phase_w-1:0]  rx_phase,
  output logic [level_w-1:0]  level,

  output logic                sync,
  output logic                gate
);

  logic armed; // low through reset and the cycle after.

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      armed <= 1'b0;
    else
      armed <= 1'b1;
  end

  // ====================================================================
  // transmit side, counts clocks
  // ====================================================================
  logic [dur_w-1:0]   tx_cntr;
  logic               tx_busy;
  logic               tx_accept;
  logic               held_sync;
  logic               held_gate;
  logic               next_sync;
  logic               next_gate;
  logic               sync_q;
  logic               gate_q;
  logic [level_w-1:0] level_q;
  logic [phase_w-1:0] tx_phase_q;
  logic [phase_w-1:0] rx_phase_q;

  assign tx_busy      = |tx_cntr;
  assign tx_evt_ready = armed & ~tx_busy;
  assign tx_accept    = tx_evt_valid & tx_evt_ready;

  // held bits while playing, fresh ones on the accept cycle.
  assign next_sync = tx_busy ? held_sync : (tx_evt_data.sync_bit & tx_accept);
  assign next_gate = tx_busy ? held_gate : (tx_evt_data.gate_bit & tx_accept);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      tx_cntr    <= '0;
      held_sync  <= 1'b0;
      held_gate  <= 1'b0;
      level_q    <= '0;
      tx_phase_q <= '0;
      rx_phase_q <= '0;
      sync_q     <= 1'b0;
      gate_q     <= 1'b0;
    end
    else
    begin
      if (tx_busy)
        tx_cntr <= tx_cntr - 1'b1;
      else if (tx_accept)
      begin
        tx_cntr    <= tx_evt_data.duration;
        held_sync  <= tx_evt_data.sync_bit;
        held_gate  <= tx_evt_data.gate_bit;
        level_q    <= tx_evt_data.level;
        tx_phase_q <= tx_evt_data.tx_phase;
        rx_phase_q <= tx_evt_data.rx_phase;
      end
      sync_q <= next_sync;
      gate_q <= next_gate;
    end
  end

  // ====================================================================
  // receive side, counts samples
  // ====================================================================
  logic [dur_w-1:0]    rx_cntr;
  logic                rx_busy;
  logic                rx_accept;
  logic                held_enable;
  logic                window_en;
  logic                out_valid_q;
  logic [sample_w-1:0] out_data_q;

  assign rx_busy      = |rx_cntr;
  assign rx_evt_ready = armed & ~rx_busy & sample_valid; // accept on a sample only.
  assign rx_accept    = rx_evt_valid & rx_evt_ready;
  assign window_en    = rx_busy ? held_enable : (rx_evt_data.rx_enable & rx_accept);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rx_cntr     <= '0;
      held_enable <= 1'b0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      if (sample_valid)
      begin
        if (rx_busy)
          rx_cntr <= rx_cntr - 1'b1;
        else if (rx_accept)
        begin
          rx_cntr     <= rx_evt_data.duration;
          held_enable <= rx_evt_data.rx_enable;
        end
      end
      out_valid_q <= sample_valid & window_en;
    end
  end

  always_ff @(posedge aclk)
    out_data_q <= sample_data; // previous cycle's sample.

  assign out_data  = out_data_q;
  assign out_valid = out_valid_q;
  assign tx_phase  = tx_phase_q;
  assign rx_phase  = rx_phase_q;
  assign level     = level_q;
  assign sync      = sync_q;
  assign gate      = gate_q;

endmodule

// File: src/event_fifo.sv
module event_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  fifo_depth = 16
)
(
  input  logic     aclk,
  input  logic     aresetn,

  input  payload_t wr_data,
  input  logic     wr_en,
  output logic     full,

  output payload_t rd_data,
  output logic     rd_valid,
  input  logic     rd_ready
);

  localparam int addr_w = $clog2(fifo_depth);

  payload_t mem [fifo_depth];

  // pointers carry one extra wrap bit.
  logic [addr_w:0] wr_ptr;
  logic [addr_w:0] rd_ptr;
  logic            empty;
  logic            do_write;
  logic            do_read;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                 (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  assign do_write = wr_en & ~full;       // writes while full are dropped.
  assign do_read  = rd_ready & ~empty;

  // ====================================================================
  // pointers
  // ====================================================================
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (do_write)
      mem[wr_ptr[addr_w-1:0]] <= wr_data;
  end

  // head entry shows without read latency.
  assign rd_data  = mem[rd_ptr[addr_w-1:0]];
  assign rd_valid = ~empty;

endmodule

// File: src/gate_pkg.sv
package gate_pkg;

  localparam int dur_w    = 40;
  localparam int phase_w  = 30;
  localparam int level_w  = 16;
  localparam int sample_w = 128;

  // transmit event, 128 bits, duration in the low bits.
  typedef struct packed {
    logic [7:0]         padding;
    logic [phase_w-1:0] rx_phase;
    logic [phase_w-1:0] tx_phase;
    logic [level_w-1:0] level;
    logic [1:0]         spare;
    logic               gate_bit;
    logic               sync_bit;
    logic [dur_w-1:0]   duration;
  } tx_event_t;

  // receive event, 64 bits, duration counted in samples.
  typedef struct packed {
    logic [22:0]      padding;
    logic             rx_enable;
    logic [dur_w-1:0] duration;
  } rx_event_t;

  // bit positions inside the flat event words.
  localparam int tx_sync_pos     = 40;
  localparam int tx_gate_pos     = 41;
  localparam int tx_level_lsb    = 44;
  localparam int tx_phase_lsb    = 60;
  localparam int tx_rx_phase_lsb = 90;
  localparam int rx_enable_pos   = 40;

endpackage
